// File: include/memGame_macros.svh
`ifndef MEMGAME_MACROS_SVH
`define MEMGAME_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// Board geometry
//////////////////////////////////////////////////////////////////////

// Sixteen cards, pairs are 2k and 2k+1
`define MG_NUM_CARDS 16
`define MG_CARD_W 4

// Score counts pairs, up to eight
`define MG_SCORE_W 4

//////////////////////////////////////////////////////////////////////
// Buffers and flow control
//////////////////////////////////////////////////////////////////////

// Pick buffer entries, also the sender's credits after reset
`define MG_PICK_DEPTH 4

// Event buffer entries, also the engine's initial egress credits
`define MG_EVT_DEPTH 4

// Cycles both cards stay up after a mismatch
`define MG_SHOW_CYCLES 20

`endif

// File: rtl/memGamePkg.sv
`include "memGame_macros.svh"

package memGamePkg;

    //////////////////////////////////////////////////////////////////////
    // Engine state and opcodes
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        pickFirst,
        pickSecond,
        compare,
        showMismatch
    } gameState_e;

    typedef enum logic [0:0] {
        opPick,
        opNewGame
    } pickOp_e;

    typedef enum logic [2:0] {
        evFlip,
        evMatch,
        evMismatch,
        evHide,
        evReject,
        evNewGame
    } eventKind_e;

    //////////////////////////////////////////////////////////////////////
    // Records crossing the boundaries
    //////////////////////////////////////////////////////////////////////

    // Player command, card is ignored for a new game
    typedef struct packed {
        pickOp_e                op;
        logic [`MG_CARD_W-1:0]  card;
    } pick_t;

    // One outcome, score is the value after the event
    typedef struct packed {
        eventKind_e             kind;
        logic [`MG_CARD_W-1:0]  cardA;
        logic [`MG_CARD_W-1:0]  cardB;
        logic [`MG_SCORE_W-1:0] score;
    } gameEvent_t;

endpackage

// File: rtl/pickIngress.sv
`timescale 1ns/1ns
`include "memGame_macros.svh"

module pickIngress (
    input  logic              clk,
    input  logic              rst,
    input  logic              pickValid,
    input  memGamePkg::pick_t pickData,
    output logic              pickCredit,
    output memGamePkg::pick_t inPick,
    output logic              inPickValid,
    input  logic              inPickPop
);

    localparam int DEPTH = `MG_PICK_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    memGamePkg::pick_t mem [DEPTH];

    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] count;
    logic             wrEn;
    logic             rdEn;

    //////////////////////////////////////////////////////////////////////
    // Handshake decode
    //////////////////////////////////////////////////////////////////////

    // Sender only sends on a credit, so a full buffer never sees a write
    assign wrEn = pickValid && (count != CNT_W'(DEPTH));
    assign rdEn = inPickPop && inPickValid;

    // Head is visible as soon as count moves off zero
    assign inPickValid = (count != '0);
    assign inPick      = mem[rdPtr];

    //////////////////////////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrPtr] <= pickData;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Pointers, occupancy and credit return
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr      <= '0;
            rdPtr      <= '0;
            count      <= '0;
            pickCredit <= 1'b0;
        end else begin
            if (wrEn) begin
                // Wrap explicitly so any depth works
                if (wrPtr == PTR_W'(DEPTH - 1)) begin
                    wrPtr <= '0;
                end else begin
                    wrPtr <= wrPtr + 1'b1;
                end
            end

            if (rdEn) begin
                if (rdPtr == PTR_W'(DEPTH - 1)) begin
                    rdPtr <= '0;
                end else begin
                    rdPtr <= rdPtr + 1'b1;
                end
            end

            case ({wrEn, rdEn})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            // One credit per freed slot, the cycle after the pop
            pickCredit <= rdEn;
        end
    end

endmodule

// File: rtl/matchEngine.sv
`timescale 1ns/1ns
`include "memGame_macros.svh"

module matchEngine (
    input  logic                    clk,
    input  logic                    rst,
    input  memGamePkg::pick_t       inPick,
    input  logic                    inPickValid,
    output logic                    inPickPop,
    output memGamePkg::gameEvent_t  engEvt,
    output logic                    engEvtValid,
    input  logic                    engEvtCredit,
    output logic [`MG_SCORE_W-1:0]  score,
    output logic                    allMatched
);

    localparam int CREDIT_W = $clog2(`MG_EVT_DEPTH + 1);
    localparam int SHOW_W   = $clog2(`MG_SHOW_CYCLES + 1);
    localparam int PAIRS    = `MG_NUM_CARDS / 2;

    memGamePkg::gameState_e state;

    logic [`MG_NUM_CARDS-1:0] board;
    logic [`MG_CARD_W-1:0]    firstCard;
    logic [`MG_CARD_W-1:0]    secondCard;
    logic [SHOW_W-1:0]        showCnt;
    logic [CREDIT_W-1:0]      credits;

    logic haveCredit;
    logic pickTaken;
    logic isNewGame;
    logic cardUp;
    logic pairMatch;
    logic showDone;

    //////////////////////////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////////////////////////

    assign haveCredit = (credits != '0);

    // Picks are only taken while waiting for a card and with a credit
    assign pickTaken = inPickValid && haveCredit &&
                       (state == memGamePkg::pickFirst ||
                        state == memGamePkg::pickSecond);
    assign inPickPop = pickTaken;

    assign isNewGame = (inPick.op == memGamePkg::opNewGame);

    // Covers a repeat of the first card too, it is already up
    assign cardUp = board[inPick.card];

    // Pair partners differ only in bit 0
    assign pairMatch = (firstCard[`MG_CARD_W-1:1] == secondCard[`MG_CARD_W-1:1]);

    // Hide fires MG_SHOW_CYCLES cycles after the mismatch event
    assign showDone = (showCnt >= SHOW_W'(`MG_SHOW_CYCLES - 1));

    assign allMatched = (score == `MG_SCORE_W'(PAIRS));

    //////////////////////////////////////////////////////////////////////
    // Event generation
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        engEvtValid  = 1'b0;
        engEvt.kind  = memGamePkg::evReject;
        engEvt.cardA = inPick.card;
        engEvt.cardB = inPick.card;
        engEvt.score = score;

        case (state)
            memGamePkg::pickFirst, memGamePkg::pickSecond: begin
                if (pickTaken) begin
                    engEvtValid = 1'b1;
                    if (isNewGame) begin
                        engEvt.kind  = memGamePkg::evNewGame;
                        engEvt.score = '0;
                    end else if (cardUp) begin
                        engEvt.kind = memGamePkg::evReject;
                    end else begin
                        engEvt.kind = memGamePkg::evFlip;
                    end
                end
            end

            memGamePkg::compare: begin
                engEvt.cardA = firstCard;
                engEvt.cardB = secondCard;
                if (haveCredit) begin
                    engEvtValid = 1'b1;
                    if (pairMatch) begin
                        engEvt.kind  = memGamePkg::evMatch;
                        engEvt.score = score + 1'b1;
                    end else begin
                        engEvt.kind = memGamePkg::evMismatch;
                    end
                end
            end

            memGamePkg::showMismatch: begin
                engEvt.kind  = memGamePkg::evHide;
                engEvt.cardA = firstCard;
                engEvt.cardB = secondCard;
                engEvtValid  = showDone && haveCredit;
            end

            default: begin
                engEvtValid = 1'b0;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Game state
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= memGamePkg::pickFirst;
            board   <= '0;
            score   <= '0;
            showCnt <= '0;
            credits <= CREDIT_W'(`MG_EVT_DEPTH);
        end else begin
            // Spend one per event, regain one per egress send
            credits <= credits - CREDIT_W'(engEvtValid) + CREDIT_W'(engEvtCredit);

            case (state)
                memGamePkg::pickFirst, memGamePkg::pickSecond: begin
                    if (pickTaken) begin
                        if (isNewGame) begin
                            board <= '0;
                            score <= '0;
                            state <= memGamePkg::pickFirst;
                        end else if (!cardUp) begin
                            board[inPick.card] <= 1'b1;
                            if (state == memGamePkg::pickFirst) begin
                                state <= memGamePkg::pickSecond;
                            end else begin
                                state <= memGamePkg::compare;
                            end
                        end
                    end
                end

                memGamePkg::compare: begin
                    if (haveCredit) begin
                        if (pairMatch) begin
                            score <= score + 1'b1;
                            state <= memGamePkg::pickFirst;
                        end else begin
                            showCnt <= '0;
                            state   <= memGamePkg::showMismatch;
                        end
                    end
                end

                memGamePkg::showMismatch: begin
                    if (!showDone) begin
                        showCnt <= showCnt + 1'b1;
                    end else if (haveCredit) begin
                        board[firstCard]  <= 1'b0;
                        board[secondCard] <= 1'b0;
                        state             <= memGamePkg::pickFirst;
                    end
                end

                default: begin
                    state <= memGamePkg::pickFirst;
                end
            endcase
        end
    end

    // Card registers hold payload only
    always_ff @(posedge clk) begin
        if (pickTaken && !isNewGame && !cardUp) begin
            if (state == memGamePkg::pickFirst) begin
                firstCard <= inPick.card;
            end else begin
                secondCard <= inPick.card;
            end
        end
    end

endmodule

// File: rtl/eventEgress.sv
`timescale 1ns/1ns
`include "memGame_macros.svh"

module eventEgress (
    input  logic                   clk,
    input  logic                   rst,
    input  memGamePkg::gameEvent_t engEvt,
    input  logic                   engEvtValid,
    output logic                   engEvtCredit,
    output memGamePkg::gameEvent_t evData,
    output logic                   evValid,
    input  logic                   evCredit
);

    localparam int DEPTH = `MG_EVT_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    memGamePkg::gameEvent_t mem [DEPTH];

    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] extCredits;
    logic             wrEn;
    logic             send;

    //////////////////////////////////////////////////////////////////////
    // Send decision
    //////////////////////////////////////////////////////////////////////

    // Engine credits keep the buffer from overflowing
    assign wrEn = engEvtValid && (count != CNT_W'(DEPTH));

    // Head goes out only while the consumer has granted room
    assign send    = (count != '0) && (extCredits != '0);
    assign evValid = send;
    assign evData  = mem[rdPtr];

    // Slot frees in the send cycle, so the engine regains it right away
    assign engEvtCredit = send;

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrPtr] <= engEvt;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Pointers and credit counter
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr      <= '0;
            rdPtr      <= '0;
            count      <= '0;
            extCredits <= CNT_W'(DEPTH);
        end else begin
            if (wrEn) begin
                wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (send) begin
                rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end

            case ({wrEn, send})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            extCredits <= extCredits - CNT_W'(send) + CNT_W'(evCredit);
        end
    end

endmodule

// File: rtl/memGameTop.sv
`timescale 1ns/1ns
`include "memGame_macros.svh"

module memGameTop (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   pickValid,
    input  memGamePkg::pick_t      pickData,
    output logic                   pickCredit,
    output memGamePkg::gameEvent_t evData,
    output logic                   evValid,
    input  logic                   evCredit,
    output logic [`MG_SCORE_W-1:0] score,
    output logic                   allMatched
);

    //////////////////////////////////////////////////////////////////////
    // Internal links
    //////////////////////////////////////////////////////////////////////

    // Pick buffer to engine
    memGamePkg::pick_t inPick;
    logic              inPickValid;
    logic              inPickPop;

    // Engine to event buffer
    memGamePkg::gameEvent_t engEvt;
    logic                   engEvtValid;
    logic                   engEvtCredit;

    pickIngress uIngress (
        .clk         (clk),
        .rst         (rst),
        .pickValid   (pickValid),
        .pickData    (pickData),
        .pickCredit  (pickCredit),
        .inPick      (inPick),
        .inPickValid (inPickValid),
        .inPickPop   (inPickPop)
    );

    matchEngine uEngine (
        .clk          (clk),
        .rst          (rst),
        .inPick       (inPick),
        .inPickValid  (inPickValid),
        .inPickPop    (inPickPop),
        .engEvt       (engEvt),
        .engEvtValid  (engEvtValid),
        .engEvtCredit (engEvtCredit),
        .score        (score),
        .allMatched   (allMatched)
    );

    eventEgress uEgress (
        .clk          (clk),
        .rst          (rst),
        .engEvt       (engEvt),
        .engEvtValid  (engEvtValid),
        .engEvtCredit (engEvtCredit),
        .evData       (evData),
        .evValid      (evValid),
        .evCredit     (evCredit)
    );

endmodule

// File: sim/memGame_asserts.sv
`timescale 1ns/1ns
`include "memGame_macros.svh"

module memGame_asserts #(
    parameter bit CHECK_STATE = 1'b1
) (
    input logic                   clk,
    input logic                   rst,
    input logic                   evtValid,
    input logic                   creditRet,
    input memGamePkg::gameState_e state,
    input logic                   pop
);

    localparam int CNT_W = $clog2(`MG_EVT_DEPTH + 1);

    // Credits held on the sending side, rebuilt from the link pulses
    logic [CNT_W-1:0] heldCredits;

    always_ff @(posedge clk) begin
        if (rst) begin
            heldCredits <= CNT_W'(`MG_EVT_DEPTH);
        end else begin
            heldCredits <= heldCredits - CNT_W'(evtValid) + CNT_W'(creditRet);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Credit rules
    //////////////////////////////////////////////////////////////////////

    // An event goes out only against a held credit
    noEventWithoutCredit: assert property (
        @(posedge clk) disable iff (rst) evtValid |-> (heldCredits != '0)
    ) else $error("event issued with zero credits");

    //////////////////////////////////////////////////////////////////////
    // State rules
    //////////////////////////////////////////////////////////////////////

    generate
        if (CHECK_STATE) begin : stateRules
            resetToPickFirst: assert property (
                @(posedge clk) rst |=> (state == memGamePkg::pickFirst)
            ) else $error("state is not pickFirst after reset");

            // Cards on show block the pick buffer
            noPopWhileShowing: assert property (
                @(posedge clk) disable iff (rst)
                    (state == memGamePkg::showMismatch) |-> !pop
            ) else $error("pick popped during showMismatch");
        end
    endgenerate

endmodule

bind matchEngine memGame_asserts engineChecks (
    .clk       (clk),
    .rst       (rst),
    .evtValid  (engEvtValid),
    .creditRet (engEvtCredit),
    .state     (state),
    .pop       (inPickPop)
);

// Egress carries no game state
bind eventEgress memGame_asserts #(.CHECK_STATE(1'b0)) egressChecks (
    .clk       (clk),
    .rst       (rst),
    .evtValid  (evValid),
    .creditRet (evCredit),
    .state     (memGamePkg::pickFirst),
    .pop       (1'b0)
);

// File: sim/memGame_tb.sv
`timescale 1ns/1ns
`include "memGame_macros.svh"

module memGame_tb;

    localparam int WAIT_LIMIT   = 1000;
    localparam int STALL_CYCLES = 40;
    localparam int SHOW         = `MG_SHOW_CYCLES;

    logic                   clk;
    logic                   rst;
    logic                   pickValid;
    memGamePkg::pick_t      pickData;
    logic                   pickCredit;
    memGamePkg::gameEvent_t evData;
    logic                   evValid;
    logic                   evCredit = 1'b0;
    logic [`MG_SCORE_W-1:0] score;
    logic                   allMatched;

    // Monitor side
    memGamePkg::gameEvent_t evLog[$];
    int                     evStamp[$];
    int                     cycleCount    = 0;
    int                     owedCredits   = 0;
    int                     returnedPicks = 0;
    bit                     creditOn      = 1'b1;

    // Driver side and reference model
    int                     sentPicks    = 0;
    memGamePkg::gameEvent_t expLog[$];
    int                     expLevel[$];
    int                     checkedCount = 0;
    bit                     faceUp[`MG_NUM_CARDS];
    bit                     haveFirst    = 1'b0;
    int                     firstCard    = 0;
    int                     modelScore   = 0;

    memGameTop DUT (
        .clk        (clk),
        .rst        (rst),
        .pickValid  (pickValid),
        .pickData   (pickData),
        .pickCredit (pickCredit),
        .evData     (evData),
        .evValid    (evValid),
        .evCredit   (evCredit),
        .score      (score),
        .allMatched (allMatched)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Event monitor and credit bookkeeping
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (rst) begin
            evCredit    <= 1'b0;
            owedCredits = 0;
        end else begin
            cycleCount = cycleCount + 1;
            if (pickCredit) begin
                returnedPicks = returnedPicks + 1;
            end
            if (evValid) begin
                evLog.push_back(evData);
                evStamp.push_back(cycleCount);
                owedCredits = owedCredits + 1;
            end
            // One credit back per cycle, held while a test withholds them
            if (creditOn && owedCredits > 0) begin
                evCredit    <= 1'b1;
                owedCredits = owedCredits - 1;
            end else begin
                evCredit <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checking and failure reporting
    //////////////////////////////////////////////////////////////////////

    task automatic checkValue(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s expected %0d actual %0d", what, expected, actual);
            $display("Verification failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic reportTimeout(input string what);
        $display("Timed out while waiting for %s", what);
        $display("Verification failed");
        $fatal(1, "Stopped on a timeout");
    endtask

    function automatic int availCredits();
        return `MG_PICK_DEPTH - sentPicks + returnedPicks;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    // Level 0 checks kind and score, 1 adds cardA, 2 adds cardB
    function automatic void addExpected(input memGamePkg::eventKind_e kind, input int cardA,
                                        input int cardB, input int s, input int level);
        memGamePkg::gameEvent_t e;
        e.kind  = kind;
        e.cardA = `MG_CARD_W'(cardA);
        e.cardB = `MG_CARD_W'(cardB);
        e.score = `MG_SCORE_W'(s);
        expLog.push_back(e);
        expLevel.push_back(level);
    endfunction

    function automatic void modelPick(input memGamePkg::pick_t p);
        int c;
        c = int'(p.card);
        if (p.op == memGamePkg::opNewGame) begin
            foreach (faceUp[i]) begin
                faceUp[i] = 1'b0;
            end
            haveFirst  = 1'b0;
            modelScore = 0;
            addExpected(memGamePkg::evNewGame, c, c, 0, 0);
        end else if (faceUp[c]) begin
            // Already up, includes a repeat of the first card
            addExpected(memGamePkg::evReject, c, c, modelScore, 1);
        end else begin
            faceUp[c] = 1'b1;
            addExpected(memGamePkg::evFlip, c, c, modelScore, 1);
            if (!haveFirst) begin
                haveFirst = 1'b1;
                firstCard = c;
            end else begin
                haveFirst = 1'b0;
                if ((firstCard / 2) == (c / 2)) begin
                    modelScore = modelScore + 1;
                    addExpected(memGamePkg::evMatch, firstCard, c, modelScore, 2);
                end else begin
                    addExpected(memGamePkg::evMismatch, firstCard, c, modelScore, 2);
                    addExpected(memGamePkg::evHide, firstCard, c, modelScore, 2);
                    faceUp[firstCard] = 1'b0;
                    faceUp[c]         = 1'b0;
                end
            end
        end
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Driver
    //////////////////////////////////////////////////////////////////////

    task automatic waitCredit(input int limit, output bit got);
        int waited;
        waited = 0;
        @(negedge clk);
        while (availCredits() == 0 && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        got = (availCredits() != 0);
    endtask

    task automatic pushPick(input memGamePkg::pick_t p);
        @(posedge clk);
        pickValid <= 1'b1;
        pickData  <= p;
        sentPicks = sentPicks + 1;
        @(posedge clk);
        pickValid <= 1'b0;
    endtask

    task automatic sendPick(input memGamePkg::pick_t p);
        bit got;
        waitCredit(WAIT_LIMIT, got);
        if (!got) begin
            reportTimeout("a pick credit");
        end else begin
            pushPick(p);
            modelPick(p);
        end
    endtask

    task automatic playPick(input int card);
        memGamePkg::pick_t p;
        p.op   = memGamePkg::opPick;
        p.card = `MG_CARD_W'(card);
        sendPick(p);
    endtask

    task automatic playNewGame();
        memGamePkg::pick_t p;
        p.op   = memGamePkg::opNewGame;
        p.card = '0;
        sendPick(p);
    endtask

    task automatic waitEvents(input int n, input string what);
        int waited;
        waited = 0;
        while (evLog.size() < n && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (evLog.size() < n) begin
            reportTimeout(what);
        end
    endtask

    task automatic checkEvents(input string name);
        int i;
        waitEvents(expLog.size(), {"events of ", name});
        for (i = checkedCount; i < expLog.size(); i++) begin
            checkValue($sformatf("%s event %0d kind", name, i),
                       32'(expLog[i].kind), 32'(evLog[i].kind));
            if (expLevel[i] > 0) begin
                checkValue($sformatf("%s event %0d cardA", name, i),
                           32'(expLog[i].cardA), 32'(evLog[i].cardA));
            end
            if (expLevel[i] > 1) begin
                checkValue($sformatf("%s event %0d cardB", name, i),
                           32'(expLog[i].cardB), 32'(evLog[i].cardB));
            end
            checkValue($sformatf("%s event %0d score", name, i),
                       32'(expLog[i].score), 32'(evLog[i].score));
        end
        checkedCount = expLog.size();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////////

    task automatic testReset();
        @(negedge clk);
        checkValue("reset pickCredit", 0, 32'(pickCredit));
        checkValue("reset evValid", 0, 32'(evValid));
        checkValue("reset score", 0, 32'(score));
        checkValue("reset allMatched", 0, 32'(allMatched));
    endtask

    task automatic testMatchPair();
        playPick(6);
        playPick(7);
        checkEvents("matchPair");
        checkValue("matchPair score port", 1, 32'(score));
    endtask

    task automatic testMismatch();
        int base;
        int gap;
        base = expLog.size();
        playPick(2);
        playPick(5);
        checkEvents("mismatch");
        gap = evStamp[base + 3] - evStamp[base + 2];
        checkValue("mismatch show time", SHOW, (gap >= SHOW) ? SHOW : gap);
        // Card 2 went face down, so it flips again
        playPick(2);
        playPick(3);
        checkEvents("mismatch reflip");
    endtask

    task automatic testRejects();
        playPick(8);
        playPick(8);
        playPick(6);
        playPick(9);
        checkEvents("rejects");
        checkValue("rejects score port", 3, 32'(score));
    endtask

    task automatic testBackPressure();
        int                cards[12] = '{0, 1, 4, 5, 10, 11, 12, 13, 14, 15, 0, 2};
        int                idx;
        int                seenBefore;
        bit                got;
        memGamePkg::pick_t p;
        creditOn   = 1'b0;
        seenBefore = evLog.size();
        idx        = 0;
        got        = 1'b1;
        // Send until the credits dry up for a long stretch
        while (idx < 12 && got) begin
            waitCredit(STALL_CYCLES, got);
            if (got) begin
                p.op   = memGamePkg::opPick;
                p.card = `MG_CARD_W'(cards[idx]);
                pushPick(p);
                modelPick(p);
                idx++;
            end
        end
        checkValue("backPressure pickCredit stalled", 0, 32'(got));
        checkValue("backPressure events seen", `MG_EVT_DEPTH,
                   (evLog.size() - seenBefore <= `MG_EVT_DEPTH) ?
                   `MG_EVT_DEPTH : evLog.size() - seenBefore);
        creditOn = 1'b1;
        while (idx < 12) begin
            playPick(cards[idx]);
            idx++;
        end
        checkEvents("backPressure");
        checkValue("backPressure score port", 8, 32'(score));
        checkValue("backPressure allMatched", 1, 32'(allMatched));
    endtask

    task automatic testNewGame();
        playNewGame();
        checkEvents("newGame");
        checkValue("newGame score port", 0, 32'(score));
        checkValue("newGame allMatched", 0, 32'(allMatched));
        playPick(6);
        playPick(7);
        checkEvents("newGame replay");
    endtask

    task automatic testFullGame();
        int order[8];
        int i;
        int j;
        int tmp;
        int a;
        playNewGame();
        for (i = 0; i < 8; i++) begin
            order[i] = i;
        end
        for (i = 7; i > 0; i--) begin
            j        = int'($urandom % (i + 1));
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (i = 0; i < 8; i++) begin
            a = order[i] * 2 + int'($urandom % 2);
            // The first pair always, later ones sometimes, meet a stranger first
            if (i < 7 && (i == 0 || ($urandom % 2) == 1)) begin
                playPick(a);
                playPick(order[i + 1] * 2);
            end
            playPick(a);
            playPick(a ^ 1);
        end
        checkEvents("fullGame");
        checkValue("fullGame score port", 8, 32'(score));
        checkValue("fullGame allMatched", 1, 32'(allMatched));
    endtask

    initial begin
        rst       = 1'b1;
        pickValid = 1'b0;
        pickData  = '0;
        void'($urandom(2632));
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        testReset();
        testMatchPair();
        testMismatch();
        testRejects();
        testBackPressure();
        testNewGame();
        testFullGame();
        // Nothing beyond the model's events may show up
        repeat (30) @(negedge clk);
        checkValue("total event count", expLog.size(), evLog.size());
        $display("Verification passed");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+include
rtl/memGamePkg.sv
rtl/pickIngress.sv
rtl/matchEngine.sv
rtl/eventEgress.sv
rtl/memGameTop.sv
sim/memGame_asserts.sv
sim/memGame_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Compile with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module memGame_tb \
    -f filelist.f -o memGameSim \
    || { echo "Build failed"; exit 1; }

./obj_dir/memGameSim | tee /dev/stderr | grep -x "Verification passed" > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
